// ==== common/ntm_gate_config.svh ====
// Write weighting configuration
// Fixed-point format and sigmoid segment breakpoints

`ifndef NTM_GATE_CONFIG_SVH
`define NTM_GATE_CONFIG_SVH

// Word width and binary point of every value
`define NTM_DATA_WIDTH 16
`define NTM_FRAC_BITS 12

// Sigmoid breakpoints on |x|, scaled by 2^12
// 5.0
`define NTM_SEG_SAT 20480
// 2.375
`define NTM_SEG_HIGH 9728
// 1.0
`define NTM_SEG_MID 4096

`endif

// ==== common/ntm_gate_pkg.sv ====
// Write weighting package
// Fixed-point word type, sigmoid segment names and the unit constant

`include "ntm_gate_config.svh"

package ntm_gate_pkg;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  // Signed word with NTM_FRAC_BITS fraction bits
  typedef logic signed [`NTM_DATA_WIDTH-1:0] fixed_t;

  // Linear piece chosen by the sigmoid approximation
  typedef enum logic [1:0] {
    // |x| below 1
    SEG_LOW,
    // 1 up to 2.375
    SEG_MID,
    // 2.375 up to 5
    SEG_HIGH,
    // Flat at one
    SEG_SAT
  } sig_segment_e;

  //////////////////////////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////////////////////////

  // 1.0 in the fixed-point format
  localparam fixed_t fixed_one = fixed_t'(1 << `NTM_FRAC_BITS);

endpackage

// ==== common/gate_stream_if.sv ====
// Gate stream between write gate and blend stage
// Carries squashed gates plus the a and c weights under valid/ready

interface gate_stream_if;
  import ntm_gate_pkg::*;

  // Handshake
  logic   valid;
  logic   ready;

  // Squashed write and allocation gates
  fixed_t gw;
  fixed_t ga;

  // Allocation and content weights, passed along with the gates
  fixed_t a;
  fixed_t c;

  // Producer side
  modport src (
    output valid, gw, ga, a, c,
    input  ready
  );

  // Consumer side
  modport dst (
    input  valid, gw, ga, a, c,
    output ready
  );

endinterface

// ==== logistic/scalar_logistic.sv ====
// Scalar logistic function
// Two-stage piecewise-linear sigmoid built from shifts and adds

`include "ntm_gate_config.svh"

module scalar_logistic (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  ntm_gate_pkg::fixed_t x,
  output logic                 out_valid,
  input  logic                 out_ready,
  output ntm_gate_pkg::fixed_t y
);
  import ntm_gate_pkg::*;

  localparam int W = `NTM_DATA_WIDTH;
  localparam int F = `NTM_FRAC_BITS;

  // Segment offsets 0.5, 0.625 and 0.84375
  localparam fixed_t OFS_LOW  = fixed_t'(1 << (F - 1));
  localparam fixed_t OFS_MID  = fixed_t'(5 << (F - 3));
  localparam fixed_t OFS_HIGH = fixed_t'(27 << (F - 5));

  logic         neg_in;
  logic [W-1:0] mag_in;
  sig_segment_e seg_in;
  logic         s1_valid;
  logic         s1_neg;
  logic [W-1:0] s1_mag;
  sig_segment_e s1_seg;
  logic         s2_ready;
  fixed_t       y_pos;
  fixed_t       y_next;

  //////////////////////////////////////////////////////////////////////
  // Stage one
  //////////////////////////////////////////////////////////////////////

  // Magnitude as unsigned, so -32768 still maps to 32768
  assign neg_in = x[W-1];
  assign mag_in = neg_in ? $unsigned(-x) : $unsigned(x);

  always_comb begin
    if (mag_in >= `NTM_SEG_SAT)
      seg_in = SEG_SAT;
    else if (mag_in >= `NTM_SEG_HIGH)
      seg_in = SEG_HIGH;
    else if (mag_in >= `NTM_SEG_MID)
      seg_in = SEG_MID;
    else
      seg_in = SEG_LOW;
  end

  // Free slot, or the held item moves on this cycle
  assign s2_ready = !out_valid || out_ready;
  assign in_ready = !s1_valid || s2_ready;

  always_ff @(posedge clk) begin
    if (rst)
      s1_valid <= 1'b0;
    else if (in_ready)
      s1_valid <= in_valid;
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      s1_neg <= neg_in;
      s1_mag <= mag_in;
      s1_seg <= seg_in;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stage two
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (s1_seg)
      SEG_SAT:  y_pos = fixed_one;
      SEG_HIGH: y_pos = fixed_t'(s1_mag >> 5) + OFS_HIGH;
      SEG_MID:  y_pos = fixed_t'(s1_mag >> 3) + OFS_MID;
      default:  y_pos = fixed_t'(s1_mag >> 2) + OFS_LOW;
    endcase
    // Odd symmetry around 0.5
    y_next = s1_neg ? fixed_one - y_pos : y_pos;
  end

  always_ff @(posedge clk) begin
    if (rst)
      out_valid <= 1'b0;
    else if (s2_ready)
      out_valid <= s1_valid;
  end

  always_ff @(posedge clk) begin
    if (s1_valid && s2_ready)
      y <= y_next;
  end

  // Output stays a probability
  a_y_range: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> (y >= 0) && (y <= fixed_one));

  // Stalled result is held
  a_y_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(y));

endmodule

// ==== hdl/write_gate.sv ====
// Write gate
// Squashes the raw write and allocation gates in lockstep
// and carries a and c alongside them

module write_gate (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  ntm_gate_pkg::fixed_t gw_hat,
  input  ntm_gate_pkg::fixed_t ga_hat,
  input  ntm_gate_pkg::fixed_t a,
  input  ntm_gate_pkg::fixed_t c,
  gate_stream_if.src           gates
);
  import ntm_gate_pkg::*;

  logic   gw_in_ready;
  logic   ga_in_ready;
  logic   gw_out_valid;
  logic   ga_out_valid;
  logic   ac_v1;
  logic   ac_v2;
  logic   ac_ready2;
  fixed_t a_q1;
  fixed_t c_q1;
  fixed_t a_q2;
  fixed_t c_q2;

  // Both units see the same input and output handshake
  assign in_ready    = gw_in_ready && ga_in_ready;
  assign gates.valid = gw_out_valid;
  assign gates.a     = a_q2;
  assign gates.c     = c_q2;

  // gw = sigmoid(gw_hat)
  scalar_logistic gw_logistic_i (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_ready (gw_in_ready),
    .x        (gw_hat),
    .out_valid(gw_out_valid),
    .out_ready(gates.ready),
    .y        (gates.gw)
  );

  // ga = sigmoid(ga_hat)
  scalar_logistic ga_logistic_i (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_ready (ga_in_ready),
    .x        (ga_hat),
    .out_valid(ga_out_valid),
    .out_ready(gates.ready),
    .y        (gates.ga)
  );

  //////////////////////////////////////////////////////////////////////
  // Side pipeline for a and c
  //////////////////////////////////////////////////////////////////////

  // Same slot rule as the logistic stages
  assign ac_ready2 = !ac_v2 || gates.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      ac_v1 <= 1'b0;
      ac_v2 <= 1'b0;
    end else begin
      if (in_ready)
        ac_v1 <= in_valid;
      if (ac_ready2)
        ac_v2 <= ac_v1;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      a_q1 <= a;
      c_q1 <= c;
    end
    if (ac_v1 && ac_ready2) begin
      a_q2 <= a_q1;
      c_q2 <= c_q1;
    end
  end

  // Gate units and side pipeline never drift apart
  a_lockstep: assert property (@(posedge clk) disable iff (rst)
    (gw_out_valid == ga_out_valid) && (ac_v2 == gw_out_valid));

endmodule

// ==== hdl/weighting_blend.sv ====
// Weighting blend
// Mixes allocation and content weights by ga, then scales by gw

`include "ntm_gate_config.svh"

module weighting_blend (
  input  logic                 clk,
  input  logic                 rst,
  gate_stream_if.dst           gates,
  output logic                 out_valid,
  input  logic                 out_ready,
  output ntm_gate_pkg::fixed_t w
);
  import ntm_gate_pkg::*;

  localparam int W = `NTM_DATA_WIDTH;
  localparam int F = `NTM_FRAC_BITS;

  logic signed [2*W-1:0] prod_a;
  logic signed [2*W-1:0] prod_c;
  logic signed [2*W-1:0] prod_w;
  fixed_t                one_minus_ga;
  fixed_t                mix_next;
  fixed_t                mix_q;
  fixed_t                gw_q;
  logic                  s1_valid;
  logic                  s2_ready;

  //////////////////////////////////////////////////////////////////////
  // Stage one
  //////////////////////////////////////////////////////////////////////

  // ga*a + (1 - ga)*c, each product truncated on its own
  assign one_minus_ga = fixed_one - gates.ga;
  assign prod_a       = gates.ga * gates.a;
  assign prod_c       = one_minus_ga * gates.c;
  assign mix_next     = fixed_t'(prod_a >>> F) + fixed_t'(prod_c >>> F);

  assign s2_ready    = !out_valid || out_ready;
  assign gates.ready = !s1_valid || s2_ready;

  always_ff @(posedge clk) begin
    if (rst)
      s1_valid <= 1'b0;
    else if (gates.ready)
      s1_valid <= gates.valid;
  end

  // gw rides along for stage two
  always_ff @(posedge clk) begin
    if (gates.valid && gates.ready) begin
      mix_q <= mix_next;
      gw_q  <= gates.gw;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stage two
  //////////////////////////////////////////////////////////////////////

  assign prod_w = mix_q * gw_q;

  always_ff @(posedge clk) begin
    if (rst)
      out_valid <= 1'b0;
    else if (s2_ready)
      out_valid <= s1_valid;
  end

  always_ff @(posedge clk) begin
    if (s1_valid && s2_ready)
      w <= fixed_t'(prod_w >>> F);
  end

  // Result is offered until taken
  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid);

endmodule

// ==== hdl/ntm_write_weighting.sv ====
// NTM write weighting
// w = sigmoid(gw_hat) * (ga*a + (1 - ga)*c) with ga = sigmoid(ga_hat)
// Four-cycle valid/ready pipeline, one memory row per item

module ntm_write_weighting (
  input  logic                 clk,
  input  logic                 rst,

  // Command side
  input  logic                 in_valid,
  output logic                 in_ready,
  input  ntm_gate_pkg::fixed_t gw_hat,
  input  ntm_gate_pkg::fixed_t ga_hat,
  input  ntm_gate_pkg::fixed_t a,
  input  ntm_gate_pkg::fixed_t c,

  // Result side
  output logic                 out_valid,
  input  logic                 out_ready,
  output ntm_gate_pkg::fixed_t w
);

  // Squashed gates with a and c
  gate_stream_if gates_if ();

  // Gate squashing, two cycles
  write_gate write_gate_i (
    .clk     (clk),
    .rst     (rst),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .gw_hat  (gw_hat),
    .ga_hat  (ga_hat),
    .a       (a),
    .c       (c),
    .gates   (gates_if.src)
  );

  // Mix and scale, two cycles
  weighting_blend weighting_blend_i (
    .clk      (clk),
    .rst      (rst),
    .gates    (gates_if.dst),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .w        (w)
  );

endmodule

// ==== bench/sigmoid_model.svh ====
// Reference model for the write weighting testbench
// Piecewise-linear sigmoid and gated blend in 16-bit fixed point

`ifndef SIGMOID_MODEL_SVH
`define SIGMOID_MODEL_SVH

`include "ntm_gate_config.svh"

// Logistic approximation of one raw fixed-point value
function automatic int sigmoid_fixed(input int x);
  int unit;
  int mag;
  int y;
  unit = 1 << `NTM_FRAC_BITS;
  mag  = (x < 0) ? -x : x;
  // Flat, then slopes 1/32, 1/8 and 1/4 toward zero
  if (mag >= `NTM_SEG_SAT)
    y = unit;
  else if (mag >= `NTM_SEG_HIGH)
    y = mag / 32 + unit * 27 / 32;
  else if (mag >= `NTM_SEG_MID)
    y = mag / 8 + unit * 5 / 8;
  else
    y = mag / 4 + unit / 2;
  // Negative side mirrored around one half
  if (x < 0)
    y = unit - y;
  return y;
endfunction

// w = gw * (ga*a + (1 - ga)*c), every product shifted right by the fraction bits
function automatic int weighting_model(input int gw_hat, input int ga_hat,
                                       input int a, input int c);
  int unit;
  int gw;
  int ga;
  int mix;
  unit = 1 << `NTM_FRAC_BITS;
  gw   = sigmoid_fixed(gw_hat);
  ga   = sigmoid_fixed(ga_hat);
  mix  = ((ga * a) >>> `NTM_FRAC_BITS) + (((unit - ga) * c) >>> `NTM_FRAC_BITS);
  // Kept to one word like the datapath
  mix  = int'(fixed_t'(mix));
  return int'(fixed_t'((mix * gw) >>> `NTM_FRAC_BITS));
endfunction

`endif

// ==== bench/ntm_write_weighting_tb.sv ====
// Testbench for the NTM write weighting pipeline
// Table-driven rows, random back-pressure and an in-order scoreboard

module ntm_write_weighting_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import ntm_gate_pkg::*;

  `include "sigmoid_model.svh"

  // Mirrored pairs first, then extremes and blend rows, then random rows
  localparam int N_SYM          = 20;
  localparam int N_DIR          = 27;
  localparam int N_RAND         = 40;
  localparam int N_ROWS         = N_DIR + N_RAND;
  localparam int LATENCY        = 4;
  localparam int TIMEOUT_CYCLES = N_ROWS * 8 + 50;

  logic   clk;
  logic   rst;
  logic   in_valid;
  logic   in_ready;
  fixed_t gw_hat;
  fixed_t ga_hat;
  fixed_t a;
  fixed_t c;
  logic   out_valid;
  logic   out_ready;
  fixed_t w;

  // Stimulus and expected-value table
  fixed_t tab_gw_hat [N_ROWS];
  fixed_t tab_ga_hat [N_ROWS];
  fixed_t tab_a      [N_ROWS];
  fixed_t tab_c      [N_ROWS];
  fixed_t tab_w      [N_ROWS];
  fixed_t got_w      [N_ROWS];

  int   seed;
  int   n_rows;
  int   cur_row;
  int   pending [$];
  int   errors;
  int   out_count;
  int   cycle;
  int   first_accept;
  int   first_out;
  int   last_out;
  logic bp_on;

  ntm_write_weighting uut (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .gw_hat   (gw_hat),
    .ga_hat   (ga_hat),
    .a        (a),
    .c        (c),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .w        (w)
  );

  always #10 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Table
  //////////////////////////////////////////////////////////////////////

  task automatic add_row(input int gw_in, input int ga_in, input int a_in, input int c_in);
    tab_gw_hat[n_rows] = fixed_t'(gw_in);
    tab_ga_hat[n_rows] = fixed_t'(ga_in);
    tab_a[n_rows]      = fixed_t'(a_in);
    tab_c[n_rows]      = fixed_t'(c_in);
    tab_w[n_rows]      = fixed_t'(weighting_model(gw_in, ga_in, a_in, c_in));
    n_rows++;
  endtask

  task automatic build_table();
    // Both sides of every breakpoint
    int sym_mag [N_SYM/2] = '{2048, 4095, 4096, 6144, 9727, 9728, 12288, 20479, 20480, 24576};
    int one;
    one = int'(fixed_one);
    // a = c = 1, so w is gw itself
    for (int k = 0; k < N_SYM / 2; k++) begin
      add_row(sym_mag[k], 0, one, one);
      add_row(-sym_mag[k], 0, one, one);
    end
    add_row(-32768, 5000, one, one);
    add_row(32767, -5000, one, one);
    // ga saturated high picks a, low picks c
    add_row(6144, 24576, 1024, 3072);
    add_row(6144, -24576, 1024, 3072);
    add_row(-4000, 30000, one, 0);
    add_row(-4000, -30000, one, 0);
    add_row(12288, 0, 1000, 3000);
    // Weights drawn from [0, 1]
    for (int k = 0; k < N_RAND; k++)
      add_row(int'(fixed_t'($random(seed))), int'(fixed_t'($random(seed))),
              int'($unsigned($random(seed)) % 4097), int'($unsigned($random(seed)) % 4097));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Driver, consumer and scoreboard
  //////////////////////////////////////////////////////////////////////

  task automatic send_rows(input int first, input int last);
    for (int i = first; i <= last; i++) begin
      @(negedge clk);
      cur_row  = i;
      in_valid = 1'b1;
      gw_hat   = tab_gw_hat[i];
      ga_hat   = tab_ga_hat[i];
      a        = tab_a[i];
      c        = tab_c[i];
      do @(posedge clk); while (!in_ready);
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic wait_outputs(input int count);
    while (out_count < count)
      @(negedge clk);
  endtask

  // Pairs the oldest accepted row with the result
  task automatic check_result(input int now);
    int row;
    assert (pending.size() > 0) else begin
      errors++;
      $display("A result appeared at cycle %0d with no input waiting for it", now);
    end
    if (pending.size() > 0) begin
      row        = pending.pop_front();
      got_w[row] = w;
      out_count++;
      if (first_out < 0)
        first_out = now;
      last_out = now;
      assert (w == tab_w[row]) else begin
        errors++;
        $display("FAILED w (row %0d): expected %h, got %h", row, tab_w[row], w);
      end
    end
  endtask

  // sigmoid(x) + sigmoid(-x) is exactly one
  task automatic check_symmetry();
    int sum;
    for (int k = 0; k < N_SYM; k += 2) begin
      sum = int'(got_w[k]) + int'(got_w[k+1]);
      assert (sum == int'(fixed_one)) else begin
        errors++;
        $display("FAILED w (rows %0d, %0d): expected sum %h, got %h", k, k + 1, fixed_one,
                 sum[15:0]);
      end
    end
  endtask

  always @(negedge clk) begin
    if (bp_on)
      out_ready = (($random(seed) & 1) != 0);
  end

  always @(posedge clk) begin
    if (!rst) begin
      cycle++;
      if (in_valid && in_ready) begin
        pending.push_back(cur_row);
        if (first_accept < 0)
          first_accept = cycle;
      end
      if (out_valid && out_ready)
        check_result(cycle);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed         = 32'he278a60d;
    clk          = 1'b0;
    rst          = 1'b1;
    in_valid     = 1'b0;
    gw_hat       = '0;
    ga_hat       = '0;
    a            = '0;
    c            = '0;
    out_ready    = 1'b1;
    bp_on        = 1'b0;
    errors       = 0;
    n_rows       = 0;
    cur_row      = 0;
    out_count    = 0;
    cycle        = 0;
    first_accept = -1;
    first_out    = -1;
    last_out     = -1;
    build_table();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Directed rows back to back, sink always ready
    send_rows(0, N_DIR - 1);
    wait_outputs(N_DIR);
    assert (first_out - first_accept == LATENCY) else begin
      errors++;
      $display("First result came %0d cycles after the first input instead of %0d",
               first_out - first_accept, LATENCY);
    end
    assert (last_out - first_out == N_DIR - 1) else begin
      errors++;
      $display("Directed results did not come out one per cycle");
    end
    check_symmetry();

    // Random rows under back-pressure
    bp_on = 1'b1;
    send_rows(N_DIR, N_ROWS - 1);
    wait_outputs(N_ROWS);
    bp_on = 1'b0;

    $display("Errors: %0d, results checked: %0d of %0d", errors, out_count, N_ROWS);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  // Bound on the whole run
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Test FAILED");
    $finish;
  end

endmodule

// ==== ntm_write_weighting.f ====
+incdir+common
+incdir+bench
common/ntm_gate_pkg.sv
common/gate_stream_if.sv
logistic/scalar_logistic.sv
hdl/write_gate.sv
hdl/weighting_blend.sv
hdl/ntm_write_weighting.sv
bench/ntm_write_weighting_tb.sv

// ==== Makefile ====
# Verilator build for the NTM write weighting testbench

VERILATOR ?= verilator
TOP       ?= ntm_write_weighting_tb
FILELIST  ?= ntm_write_weighting.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := common/ntm_gate_config.svh bench/sigmoid_model.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only if the log holds the pass line
run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -qx "Test OK" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
